//--- build.f
+incdir+verification
design/rv_isa_pkg.sv
design/rv_ctrl_pkg.sv
design/ctrl_bus_if.sv
design/decode_stage.sv
design/ctrl_table.sv
design/branch_resolve.sv
design/rv_decoder_top.sv
verification/tb_rv_decoder.sv

//--- design/branch_resolve.sv
// Flags must come from the same held instruction as the table; no branch prediction here
`timescale 1ns/1ps

module branch_resolve (
    ctrl_bus_if.branch_side ctrl,        // base_pc_sel and br_cond from the table
    input  logic            held_br_eq,  // rs1 == rs2
    input  logic            held_br_lt,  // rs1 < rs2 signed
    input  logic            held_br_ltu, // rs1 < rs2 unsigned
    output rv_ctrl_pkg::pc_sel_t pc_sel  // Final next-PC select
);
    import rv_ctrl_pkg::*;

    logic taken; // Chosen condition holds

    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   taken = held_br_eq;
            BR_NE:   taken = !held_br_eq;
            BR_LT:   taken = held_br_lt;
            BR_GE:   taken = !held_br_lt;  // Signed greater or equal
            BR_LTU:  taken = held_br_ltu;
            BR_GEU:  taken = !held_br_ltu; // Unsigned greater or equal
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.br_cond == BR_NONE) begin
            pc_sel = ctrl.base_pc_sel; // Jumps and straight-line code
        end else begin
            pc_sel = taken ? PC_BRANCH : PC_NEXT;
        end
    end

    // A conditional branch only ever falls through or takes its offset
    a_branch_no_jump: assert final (ctrl.br_cond == BR_NONE ||
                                    (pc_sel != PC_JAL && pc_sel != PC_JALR))
        else $error("branch resolved to a jump target");

    // The table leaves the branch base at PC_NEXT
    a_branch_base: assert final (ctrl.br_cond == BR_NONE || ctrl.base_pc_sel == PC_NEXT)
        else $error("branch with non-sequential base pc_sel");

endmodule

//--- design/ctrl_bus_if.sv
// One producer only; fields are combinational and valid while the capture stage holds ack high
`timescale 1ns/1ps

interface ctrl_bus_if;
    import rv_ctrl_pkg::*;

    alu_op_t     alu_op;      // ALU operation
    op1_sel_t    op1_sel;     // Operand 1 source
    op2_sel_t    op2_sel;     // Operand 2 source
    pc_sel_t     base_pc_sel; // Next PC before branch resolution
    br_cond_t    br_cond;     // Condition for conditional branches
    logic        rf_we;       // Register file write
    logic        mem_en;      // Data memory access
    logic        mem_wen;     // Data memory write
    wb_sel_t     wb_sel;      // Write-back source
    mem_access_t mem_access;  // Access width and sign
    logic        is_ebreak;   // Exact ebreak word

    modport producer (output alu_op, op1_sel, op2_sel, base_pc_sel, br_cond, rf_we,
                      output mem_en, mem_wen, wb_sel, mem_access, is_ebreak);

    modport branch_side (input base_pc_sel, br_cond);

    modport sink (input alu_op, op1_sel, op2_sel, rf_we, mem_en, mem_wen, wb_sel,
                  input mem_access, is_ebreak);

endinterface

//--- design/ctrl_table.sv
// RV32I subset of 37 instructions; any other key gives the all-zero control word
`timescale 1ns/1ps

module ctrl_table (
    input rv_isa_pkg::inst_t held_inst, // Instruction held by the capture stage
    ctrl_bus_if.producer     ctrl       // Decoded control word
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [16:0] key; // {opcode, funct3, funct7}
    logic [16:0] cw;  // {alu_op, op1, op2, pc, rf_we, mem_en, mem_wen, wb}

    assign opcode = held_inst[OPCODE_LSB +: 7];
    assign funct3 = held_inst[FUNCT3_LSB +: 3];
    assign funct7 = held_inst[FUNCT7_LSB +: 7];

    // Lookup key with the don't-care fields forced to zero
    always_comb begin
        case (opcode)
            OPC_OP_IMM: key = (funct3 == 3'd5) ? {opcode, funct3, funct7}  // SRLI vs SRAI
                                               : {opcode, funct3, 7'd0};   // funct7 is immediate
            OPC_AUIPC,
            OPC_JAL:    key = {opcode, 3'd0, 7'd0};      // Both funct fields are immediate
            OPC_STORE,
            OPC_LOAD,
            OPC_BRANCH,
            OPC_JALR:   key = {opcode, funct3, 7'd0};    // JALR misses unless funct3 is 0
            default:    key = {opcode, funct3, funct7};  // R-type and SYSTEM
        endcase
    end

    // Control-word table
    always_comb begin
        case (key)
            // R-type ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
            {OPC_OP, 3'd0, 7'd0}:   cw = {ALU_ADD, OP1_RS1, OP2_RS2, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP, 3'd0, F7_ALT}: cw = {ALU_SUB, OP1_RS1, OP2_RS2, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP, 3'd1, 7'd0}:   cw = {ALU_SLL, OP1_RS1, OP2_RS2, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP, 3'd2, 7'd0}:   cw = {ALU_SLT, OP1_RS1, OP2_RS2, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP, 3'd3, 7'd0}:   cw = {ALU_SLTU, OP1_RS1, OP2_RS2, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP, 3'd4, 7'd0}:   cw = {ALU_XOR, OP1_RS1, OP2_RS2, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP, 3'd5, 7'd0}:   cw = {ALU_SRL, OP1_RS1, OP2_RS2, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP, 3'd5, F7_ALT}: cw = {ALU_SRA, OP1_RS1, OP2_RS2, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP, 3'd6, 7'd0}:   cw = {ALU_OR, OP1_RS1, OP2_RS2, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP, 3'd7, 7'd0}:   cw = {ALU_AND, OP1_RS1, OP2_RS2, PC_NEXT, 3'b100, WB_ALU};
            // I-type ADDI SLLI SLTI SLTIU XORI SRLI SRAI ORI ANDI
            {OPC_OP_IMM, 3'd0, 7'd0}:   cw = {ALU_ADD, OP1_RS1, OP2_IMM, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP_IMM, 3'd1, 7'd0}:   cw = {ALU_SLL, OP1_RS1, OP2_IMM, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP_IMM, 3'd2, 7'd0}:   cw = {ALU_SLT, OP1_RS1, OP2_IMM, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP_IMM, 3'd3, 7'd0}:   cw = {ALU_SLTU, OP1_RS1, OP2_IMM, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP_IMM, 3'd4, 7'd0}:   cw = {ALU_XOR, OP1_RS1, OP2_IMM, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP_IMM, 3'd5, 7'd0}:   cw = {ALU_SRL, OP1_RS1, OP2_IMM, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP_IMM, 3'd5, F7_ALT}: cw = {ALU_SRA, OP1_RS1, OP2_IMM, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP_IMM, 3'd6, 7'd0}:   cw = {ALU_OR, OP1_RS1, OP2_IMM, PC_NEXT, 3'b100, WB_ALU};
            {OPC_OP_IMM, 3'd7, 7'd0}:   cw = {ALU_AND, OP1_RS1, OP2_IMM, PC_NEXT, 3'b100, WB_ALU};
            // Loads LB LH LW LBU LHU
            {OPC_LOAD, 3'd0, 7'd0}, {OPC_LOAD, 3'd1, 7'd0}, {OPC_LOAD, 3'd2, 7'd0},
            {OPC_LOAD, 3'd4, 7'd0}, {OPC_LOAD, 3'd5, 7'd0}:
                cw = {ALU_ADD, OP1_RS1, OP2_IMM, PC_NEXT, 3'b110, WB_MEM};
            // Stores SB SH then SW
            {OPC_STORE, 3'd0, 7'd0}, {OPC_STORE, 3'd1, 7'd0}:
                cw = {ALU_ADD, OP1_RS1, OP2_IMM, PC_NEXT, 3'b011, WB_NONE};
            {OPC_STORE, 3'd2, 7'd0}:
                cw = {ALU_ADD, OP1_RS1, OP2_NONE, PC_NEXT, 3'b011, WB_NONE};
            // Branches keep PC_NEXT until resolved
            {OPC_BRANCH, F3_BEQ, 7'd0}, {OPC_BRANCH, F3_BNE, 7'd0}:
                cw = {ALU_ADD, OP1_RS1, OP2_IMM, PC_NEXT, 3'b000, WB_ALU};
            {OPC_BRANCH, F3_BLT, 7'd0}, {OPC_BRANCH, F3_BGE, 7'd0},
            {OPC_BRANCH, F3_BLTU, 7'd0}, {OPC_BRANCH, F3_BGEU, 7'd0}:
                cw = {ALU_ADD, OP1_RS1, OP2_NONE, PC_NEXT, 3'b000, WB_ALU};
            // Jumps and AUIPC
            {OPC_JAL, 3'd0, 7'd0}:   cw = {ALU_ADD, OP1_RS1, OP2_NONE, PC_JAL, 3'b100, WB_PC4};
            {OPC_JALR, 3'd0, 7'd0}:  cw = {ALU_ADD, OP1_RS1, OP2_IMM, PC_JALR, 3'b100, WB_PC4};
            {OPC_AUIPC, 3'd0, 7'd0}: cw = {ALU_ADD, OP1_PC, OP2_NONE, PC_NEXT, 3'b100, WB_ALU};
            {OPC_SYSTEM, 3'd0, 7'd0}: cw = '0; // EBREAK is flagged separately
            default:                  cw = '0; // Unknown key decodes to a bubble
        endcase
    end

    // Field extraction from the packed word
    assign ctrl.alu_op      = alu_op_t'(cw[16:12]);
    assign ctrl.op1_sel     = op1_sel_t'(cw[11:10]);
    assign ctrl.op2_sel     = op2_sel_t'(cw[9:8]);
    assign ctrl.base_pc_sel = pc_sel_t'(cw[7:5]);
    assign ctrl.rf_we       = cw[4];
    assign ctrl.mem_en      = cw[3];
    assign ctrl.mem_wen     = cw[2];
    assign ctrl.wb_sel      = wb_sel_t'(cw[1:0]);
    assign ctrl.mem_access  = cw[3] ? funct3 : '0; // Only matched loads and stores set mem_en
    assign ctrl.is_ebreak   = (held_inst == INST_EBREAK);

    // Branch condition from funct3 of a valid branch
    always_comb begin
        ctrl.br_cond = BR_NONE;
        if (opcode == OPC_BRANCH) begin
            case (funct3)
                F3_BEQ:  ctrl.br_cond = BR_EQ;
                F3_BNE:  ctrl.br_cond = BR_NE;
                F3_BLT:  ctrl.br_cond = BR_LT;
                F3_BGE:  ctrl.br_cond = BR_GE;
                F3_BLTU: ctrl.br_cond = BR_LTU;
                F3_BGEU: ctrl.br_cond = BR_GEU;
                default: ctrl.br_cond = BR_NONE; // funct3 010 and 011 are reserved
            endcase
        end
    end

    a_wen_needs_en: assert final (!ctrl.mem_wen || ctrl.mem_en)
        else $error("mem_wen high without mem_en");

    a_no_rf_and_store: assert final (!(ctrl.rf_we && ctrl.mem_wen))
        else $error("rf_we and mem_wen high together");

endmodule

//--- design/decode_stage.sv
// One word in flight; requester holds inst and flags stable until ack and waits for ack low
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,         // Core clock
    input  logic              rst,         // Synchronous reset
    input  logic              req,         // Four-phase request
    output logic              ack,         // High while the held word is presented
    input  rv_isa_pkg::inst_t inst,        // Instruction from the requester
    input  logic              br_eq,       // rs1 == rs2
    input  logic              br_lt,       // rs1 < rs2 signed
    input  logic              br_ltu,      // rs1 < rs2 unsigned
    output rv_isa_pkg::inst_t held_inst,   // Captured instruction
    output logic              held_br_eq,  // Captured equal flag
    output logic              held_br_lt,  // Captured signed less-than
    output logic              held_br_ltu  // Captured unsigned less-than
);

    logic accept;   // Idle with request pending
    logic withdraw; // Acked and request dropped

    assign accept   = req && !ack;
    assign withdraw = !req && ack;

    // ack doubles as the idle/acked state bit
    always_ff @(posedge clk) begin
        if (rst) begin
            ack         <= 1'b0; // Idle
            held_inst   <= '0;   // Opcode 0 decodes to nothing
            held_br_eq  <= 1'b0;
            held_br_lt  <= 1'b0;
            held_br_ltu <= 1'b0;
        end else if (accept) begin
            ack         <= 1'b1; // Acked from next cycle
            held_inst   <= inst; // Load only on the accepting edge
            held_br_eq  <= br_eq;
            held_br_lt  <= br_lt;
            held_br_ltu <= br_ltu;
        end else if (withdraw) begin
            ack         <= 1'b0; // Back to idle
        end
    end

    // ack only ever answers a request seen on the edge before
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req)
    ) else $error("ack rose without req on the previous edge");

    // Presented word is frozen for the whole ack phase
    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        (ack && $past(ack)) |-> $stable(held_inst)
    ) else $error("held_inst changed while ack was high");

endmodule

//--- design/rv_ctrl_pkg.sv
// Encodings are fixed by the datapath muxes that consume them; changing a value breaks the datapath
package rv_ctrl_pkg;

    localparam int ALU_OP_W  = 5; // ALU operation code
    localparam int SEL_W     = 2; // op1, op2 and write-back selects
    localparam int PC_SEL_W  = 3; // Next-PC select
    localparam int MEM_ACC_W = 3; // Load/store width code
    localparam int BR_COND_W = 3; // Branch condition code

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_SLT  = 5'd2, // Signed compare
        ALU_SLTU = 5'd3, // Unsigned compare
        ALU_XOR  = 5'd4,
        ALU_OR   = 5'd5,
        ALU_AND  = 5'd6,
        ALU_SLL  = 5'd7,
        ALU_SRL  = 5'd8, // Logical right
        ALU_SRA  = 5'd9  // Arithmetic right
    } alu_op_t;

    typedef enum logic [SEL_W-1:0] {
        OP1_RS1 = 2'd0, // Register operand
        OP1_PC  = 2'd1  // Current PC for AUIPC
    } op1_sel_t;

    // Code 2 is unused by the datapath
    typedef enum logic [SEL_W-1:0] {OP2_NONE = 2'd0, OP2_IMM = 2'd1, OP2_RS2 = 2'd3} op2_sel_t;

    typedef enum logic [PC_SEL_W-1:0] {
        PC_NEXT   = 3'd0, // pc + 4
        PC_JALR   = 3'd1, // rs1 + imm
        PC_BRANCH = 3'd2, // pc + branch offset
        PC_JAL    = 3'd3  // pc + jump offset
    } pc_sel_t;

    typedef enum logic [SEL_W-1:0] {
        WB_NONE = 2'd0,
        WB_PC4  = 2'd1,
        WB_ALU  = 2'd2,
        WB_MEM  = 2'd3
    } wb_sel_t;

    typedef logic [MEM_ACC_W-1:0] mem_access_t; // Same code as load/store funct3

    typedef enum logic [BR_COND_W-1:0] {
        BR_NONE, // Not a branch
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_cond_t;

endpackage

//--- design/rv_decoder_top.sv
// Outputs are valid only while ack is high; inst and flags are sampled on the accepting edge
`timescale 1ns/1ps

module rv_decoder_top (
    input  logic                     clk,        // Core clock
    input  logic                     rst,        // Synchronous reset
    input  logic                     req,        // Four-phase request
    output logic                     ack,        // Decoded word presented
    input  rv_isa_pkg::inst_t        inst,       // Instruction to decode
    input  logic                     br_eq,      // rs1 == rs2
    input  logic                     br_lt,      // rs1 < rs2 signed
    input  logic                     br_ltu,     // rs1 < rs2 unsigned
    output rv_ctrl_pkg::alu_op_t     alu_op,     // ALU operation
    output rv_ctrl_pkg::op1_sel_t    op1_sel,    // Operand 1 source
    output rv_ctrl_pkg::op2_sel_t    op2_sel,    // Operand 2 source
    output rv_ctrl_pkg::pc_sel_t     pc_sel,     // Resolved next-PC select
    output logic                     rf_we,      // Register file write
    output logic                     mem_en,     // Data memory access
    output logic                     mem_wen,    // Data memory write
    output rv_ctrl_pkg::wb_sel_t     wb_sel,     // Write-back source
    output rv_ctrl_pkg::mem_access_t mem_access, // Load/store width
    output logic                     is_ebreak   // Breakpoint word seen
);
    import rv_isa_pkg::*;

    inst_t held_inst; // Captured instruction
    logic  held_br_eq;
    logic  held_br_lt;
    logic  held_br_ltu;

    ctrl_bus_if ctrl_bus ();

    decode_stage u_stage (
        .clk(clk), .rst(rst), .req(req), .ack(ack),
        .inst(inst), .br_eq(br_eq), .br_lt(br_lt), .br_ltu(br_ltu),
        .held_inst(held_inst), .held_br_eq(held_br_eq),
        .held_br_lt(held_br_lt), .held_br_ltu(held_br_ltu)
    );

    ctrl_table u_table (.held_inst(held_inst), .ctrl(ctrl_bus.producer));

    branch_resolve u_branch (
        .ctrl(ctrl_bus.branch_side), .held_br_eq(held_br_eq),
        .held_br_lt(held_br_lt), .held_br_ltu(held_br_ltu), .pc_sel(pc_sel)
    );

    // Remaining fields straight to the datapath
    assign alu_op     = ctrl_bus.alu_op;
    assign op1_sel    = ctrl_bus.op1_sel;
    assign op2_sel    = ctrl_bus.op2_sel;
    assign rf_we      = ctrl_bus.rf_we;
    assign mem_en     = ctrl_bus.mem_en;
    assign mem_wen    = ctrl_bus.mem_wen;
    assign wb_sel     = ctrl_bus.wb_sel;
    assign mem_access = ctrl_bus.mem_access;
    assign is_ebreak  = ctrl_bus.is_ebreak;

endmodule

//--- design/rv_isa_pkg.sv
// RV32I base encoding only; compressed, M, A, F and CSR instructions are not described here
package rv_isa_pkg;

    typedef logic [31:0] inst_t; // Raw 32-bit instruction word

    // Bit positions of the decoded fields
    localparam int OPCODE_LSB = 0;  // opcode is inst[6:0]
    localparam int FUNCT3_LSB = 12; // funct3 is inst[14:12]
    localparam int FUNCT7_LSB = 25; // funct7 is inst[31:25]

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate ALU
    localparam logic [6:0] OPC_LOAD   = 7'b0000011; // LB LH LW LBU LHU
    localparam logic [6:0] OPC_STORE  = 7'b0100011; // SB SH SW
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // Conditional branches
    localparam logic [6:0] OPC_JAL    = 7'b1101111; // Jump and link
    localparam logic [6:0] OPC_JALR   = 7'b1100111; // Jump and link register
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111; // Add upper immediate to PC
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // ECALL EBREAK CSR

    // Branch funct3 values
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100; // Signed
    localparam logic [2:0] F3_BGE  = 3'b101; // Signed
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Alternate funct7 that turns ADD into SUB and SRL into SRA
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // Breakpoint trap word matched exactly
    localparam inst_t INST_EBREAK = 32'h00100073;

endpackage

//--- verification/tb_rv_expect.svh
// Expected control words from the RV32I table rules; needs rv_isa_pkg and rv_ctrl_pkg imported first
`ifndef TB_RV_EXPECT_SVH
`define TB_RV_EXPECT_SVH

// ALU code for an OP or OP_IMM funct3, alt selects SUB or SRA
function automatic logic [4:0] alu_of(logic [2:0] f3, logic alt);
    case (f3)
        3'd0:    return alt ? ALU_SUB : ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return alt ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

// {alu_op, op1, op2, pc_sel, rf_we, mem_en, mem_wen, wb_sel, mem_access, is_ebreak}
function automatic logic [20:0] expected_ctrl(inst_t w, logic eq, logic lt, logic ltu);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [4:0] alu;
    logic [1:0] op1, op2, wb;
    logic [2:0] pc, acc;
    logic       we, en, wen, take;
    begin
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        alu = ALU_ADD;
        op1 = OP1_RS1;
        op2 = OP2_NONE;
        wb  = WB_NONE;
        pc  = PC_NEXT;
        acc = 3'd0;
        we  = 1'b0;
        en  = 1'b0;
        wen = 1'b0;
        case (opc)
            OPC_OP: if (f7 == 7'd0 || (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5))) begin
                alu = alu_of(f3, f7 == F7_ALT);
                op2 = OP2_RS2;
                we  = 1'b1;
                wb  = WB_ALU;
            end
            OPC_OP_IMM: if (f3 != 3'd5 || f7 == 7'd0 || f7 == F7_ALT) begin
                alu = alu_of(f3, f3 == 3'd5 && f7 == F7_ALT); // Shift amount only for SRAI
                op2 = OP2_IMM;
                we  = 1'b1;
                wb  = WB_ALU;
            end
            OPC_LOAD: if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
                op2 = OP2_IMM;
                we  = 1'b1;
                en  = 1'b1;
                wb  = WB_MEM;
                acc = f3;
            end
            OPC_STORE: if (f3 <= 3'd2) begin
                op2 = (f3 == 3'd2) ? OP2_NONE : OP2_IMM; // SW uses no immediate select
                en  = 1'b1;
                wen = 1'b1;
                acc = f3;
            end
            OPC_BRANCH: if (f3 != 3'd2 && f3 != 3'd3) begin
                case (f3)
                    3'd0:    take = eq;
                    3'd1:    take = !eq;
                    3'd4:    take = lt;
                    3'd5:    take = !lt;
                    3'd6:    take = ltu;
                    default: take = !ltu;
                endcase
                op2 = (f3 <= 3'd1) ? OP2_IMM : OP2_NONE;
                wb  = WB_ALU;
                pc  = take ? PC_BRANCH : PC_NEXT;
            end
            OPC_JAL: begin
                pc = PC_JAL;
                we = 1'b1;
                wb = WB_PC4;
            end
            OPC_JALR: if (f3 == 3'd0) begin
                pc  = PC_JALR;
                op2 = OP2_IMM;
                we  = 1'b1;
                wb  = WB_PC4;
            end
            OPC_AUIPC: begin
                op1 = OP1_PC;
                we  = 1'b1;
                wb  = WB_ALU;
            end
            default: ; // Unknown opcode, all zero
        endcase
        return {alu, op1, op2, pc, we, en, wen, wb, acc, w == INST_EBREAK};
    end
endfunction

`endif

//--- verification/tb_rv_decoder.sv
// Checks run only while ack is high; 120 four-phase transactions from a fixed-seed LFSR
`timescale 1ns/1ps

module tb_rv_decoder;
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
    `include "tb_rv_expect.svh"

    localparam int N_TXN       = 120;                  // Three passes over 40 forms
    localparam int TXN_MAX_CYC = 14;                   // Accept, hold up to 8, release
    localparam int CYC_LIMIT   = N_TXN * TXN_MAX_CYC + 40;

    logic clk, rst, req, ack, br_eq, br_lt, br_ltu;
    inst_t inst;
    alu_op_t alu_op;
    op1_sel_t op1_sel;
    op2_sel_t op2_sel;
    pc_sel_t pc_sel;
    wb_sel_t wb_sel;
    mem_access_t mem_access;
    logic rf_we, mem_en, mem_wen, is_ebreak;
    logic [20:0] act, exp_c;
    logic [31:0] lfsr = 32'h2557_fdd2;
    int cycles = 0;
    int value_errs = 0;
    int proto_errs = 0;
    // funct3 per form index, R then I then loads, stores, branches
    logic [2:0] f3_tab [0:32] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7, 0, 1, 2, 3, 4, 5, 5, 6, 7,
                                  0, 1, 2, 4, 5, 0, 1, 2, 0, 1, 4, 5, 6, 7};
    string fname [10] = '{"alu_op", "op1_sel", "op2_sel", "pc_sel", "rf_we", "mem_en",
                          "mem_wen", "wb_sel", "mem_access", "is_ebreak"};
    int fw [10] = '{5, 2, 2, 3, 1, 1, 1, 2, 3, 1};

    rv_decoder_top uut (.*);

    assign act   = {alu_op, op1_sel, op2_sel, pc_sel, rf_we, mem_en, mem_wen, wb_sel,
                    mem_access, is_ebreak};
    assign exp_c = expected_ctrl(inst, br_eq, br_lt, br_ltu); // Inst held until ack low

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYC_LIMIT) begin
            $display("Timeout: test did not finish within %0d cycles", CYC_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // One error line per wrong field
    task automatic report_diff(input logic [20:0] got, input logic [20:0] want);
        int pos;
        logic [20:0] mask;
        pos = 21;
        for (int k = 0; k < 10; k++) begin
            pos -= fw[k];
            mask = (21'd1 << fw[k]) - 1;
            if (((got >> pos) & mask) !== ((want >> pos) & mask)) begin
                value_errs++;
                $display("** Error at %0t: %s = %0h, expected %0h", $time, fname[k],
                         (got >> pos) & mask, (want >> pos) & mask);
            end
        end
    endtask

    a_ctrl: assert property (@(posedge clk) disable iff (rst) ack |-> act === exp_c)
        else report_diff(act, exp_c);

    a_stable: assert property (@(posedge clk) disable iff (rst)
        (ack && $past(ack)) |-> $stable(act))
    else begin
        proto_errs++;
        $display("Outputs changed while ack was high at %0t", $time);
    end

    a_rise: assert property (@(posedge clk) disable iff (rst) (req && !ack) |=> ack)
    else begin
        proto_errs++;
        $display("ack did not rise one cycle after req at %0t", $time);
    end

    a_fall: assert property (@(posedge clk) disable iff (rst) (!req && ack) |=> !ack)
    else begin
        proto_errs++;
        $display("ack did not fall one cycle after req at %0t", $time);
    end

    a_reset: assert property (@(posedge clk) $fell(rst) |-> !(ack || rf_we || mem_en || mem_wen))
    else begin
        proto_errs++;
        $display("Outputs not idle after reset at %0t", $time);
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // Form k of 40 with random register and immediate fields
    task automatic make_inst(input int k, output inst_t w);
        w = rand_bits(32);
        if (k < 33) begin
            w[14:12] = f3_tab[k];
            if (k < 10) w[6:0] = OPC_OP;
            else if (k < 19) w[6:0] = OPC_OP_IMM;
            else if (k < 24) w[6:0] = OPC_LOAD;
            else if (k < 27) w[6:0] = OPC_STORE;
            else w[6:0] = OPC_BRANCH;
            if (k < 10 || k == 11 || k == 15 || k == 16) begin
                w[31:25] = (k == 1 || k == 7 || k == 16) ? F7_ALT : 7'd0; // SUB SRA SRAI
            end
        end else begin
            case (k)
                33: w[6:0] = OPC_JAL;
                34: begin
                    w[6:0]   = OPC_JALR;
                    w[14:12] = 3'd0;
                end
                35: w[6:0] = OPC_AUIPC;
                36: w = INST_EBREAK;
                37: w[6:0] = 7'h7f;                                  // Unknown opcode
                38: begin
                    w[6:0]   = OPC_JALR;
                    w[14:12] = 3'd2;                                 // Bad JALR funct3
                end
                default: w[6:0] = OPC_SYSTEM;                       // Not an exact ebreak
            endcase
        end
    endtask

    task automatic do_txn(input inst_t w, input logic [2:0] fl, input int hold);
        @(posedge clk);
        #0.5;
        inst = w;
        {br_eq, br_lt, br_ltu} = fl;
        req = 1'b1;
        do begin
            @(posedge clk);
            #0.5;
        end while (!ack);
        repeat (hold) @(posedge clk); // Back-pressure
        #0.5 req = 1'b0;
        do begin
            @(posedge clk);
            #0.5;
        end while (ack);
    endtask

    initial begin
        inst_t w;
        logic [31:0] fl, hv;
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        inst = '0;
        {br_eq, br_lt, br_ltu} = 3'b000;
        repeat (3) @(posedge clk);
        #0.5 rst = 1'b0;
        for (int i = 0; i < N_TXN; i++) begin
            make_inst(i % 40, w);
            fl = rand_bits(3);
            hv = rand_bits(3);
            do_txn(w, fl[2:0], hv[2:0] + 1);
        end
        repeat (2) @(posedge clk);
        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
